// ==== verilog/perturb_pkg.sv ====
// Stall modes, stall-count widths, response queue sizing and LFSR constants for the perturbation unit
package perturb_pkg;

    ////////////////////////////////
    // Stall configuration
    ////////////////////////////////

    // Stall mode select, driven straight from the top-level inputs
    typedef enum logic [1:0] {
        STALL_OFF    = 2'd0,
        STALL_FIXED  = 2'd1,
        STALL_RANDOM = 2'd2
    } stall_mode_e;

    // Width of every stall setting and stall counter
    localparam int STALL_W = 8;

    ////////////////////////////////
    // Response queue
    ////////////////////////////////

    // Accesses allowed between grant and response strobe, power of two
    localparam int RESP_DEPTH = 4;
    localparam int RESP_PTR_W = $clog2(RESP_DEPTH);
    // Occupancy counters must reach RESP_DEPTH itself
    localparam int RESP_CNT_W = $clog2(RESP_DEPTH + 1);

    ////////////////////////////////
    // Random source
    ////////////////////////////////

    localparam int          LFSR_W    = 16;
    // Nonzero start value
    localparam logic [15:0] LFSR_SEED = 16'hACE1;
    // x^16 + x^14 + x^13 + x^11 + 1, right-shift Galois form
    localparam logic [15:0] LFSR_TAPS = 16'hB400;

    // Stall count for one access: zero, the fixed count, or draw mod (max + 1)
    function automatic logic [STALL_W-1:0] pick_stall(
        input stall_mode_e          mode,
        input logic [STALL_W-1:0]   fixed_cnt,
        input logic [STALL_W-1:0]   max_cnt,
        input logic [STALL_W-1:0]   draw
    );
        logic [STALL_W:0] span;
        logic [STALL_W:0] rem;
        // One extra bit so that max = all ones still gives a full range
        span = {1'b0, max_cnt} + 1'b1;
        rem  = {1'b0, draw} % span;
        case (mode)
            STALL_FIXED:  pick_stall = fixed_cnt;
            STALL_RANDOM: pick_stall = rem[STALL_W-1:0];
            default:      pick_stall = '0;
        endcase
    endfunction

endpackage

// ==== verilog/mem_bus_pkg.sv ====
// Data-port bus widths and scratch memory sizing shared by the bus interface and the memory
package mem_bus_pkg;

    ////////////////////////////////
    // Bus widths
    ////////////////////////////////

    // Byte address from the core
    localparam int ADDR_W = 32;
    // Word data in both directions
    localparam int DATA_W = 32;
    // One enable per byte lane
    localparam int BE_W   = DATA_W / 8;

    ////////////////////////////////
    // Scratch memory
    ////////////////////////////////

    // Number of 32-bit words
    localparam int MEM_WORDS = 256;
    // Word index width, taken from address bits above the byte offset
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);

endpackage

// ==== verilog/mem_req_if.sv ====
// Request bundle between the grant stage and the scratch memory, with hold-until-grant handshake
`timescale 1ns/1ps

interface mem_req_if;
    import mem_bus_pkg::*;

    // Request held high with steady fields until gnt
    logic              req;
    // Access transfers in the cycle where req and gnt are both high
    logic              gnt;

    // Request fields
    logic [ADDR_W-1:0] addr;
    logic              we;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] wdata;

    // Side that issues accesses
    modport requester (
        output req,
        output addr,
        output we,
        output be,
        output wdata,
        input  gnt
    );

    // Side that accepts accesses
    modport responder (
        input  req,
        input  addr,
        input  we,
        input  be,
        input  wdata,
        output gnt
    );

endinterface

// ==== verilog/stall_lfsr.sv ====
// Free-running 16-bit Galois LFSR that feeds random stall draws to both stall stages
`timescale 1ns/1ps

module stall_lfsr (
    input  logic                           clk_i,
    input  logic                           reset_i,
    output logic [perturb_pkg::LFSR_W-1:0] rand_o
);
    import perturb_pkg::*;

    logic [LFSR_W-1:0] lfsr_q;
    logic [LFSR_W-1:0] lfsr_d;

    // Shift right, fold the output bit back through the tap mask
    always_comb begin
        lfsr_d = {1'b0, lfsr_q[LFSR_W-1:1]};
        if (lfsr_q[0]) begin
            lfsr_d = lfsr_d ^ LFSR_TAPS;
        end
    end

    // Advances every cycle, never leaves the nonzero cycle
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            lfsr_q <= LFSR_SEED;
        end else begin
            lfsr_q <= lfsr_d;
        end
    end

    // Low byte to the grant stage, high byte to the response stage
    assign rand_o = lfsr_q;

endmodule

// ==== verilog/grant_stall_gen.sv ====
// Grant stall stage that delays the core's grant by a chosen count, then passes the request on
`timescale 1ns/1ps

module grant_stall_gen (
    input  logic                            clk_i,
    input  logic                            reset_i,

    // Core data port, request side
    input  logic                            core_req_i,
    input  logic [mem_bus_pkg::ADDR_W-1:0]  core_addr_i,
    input  logic                            core_we_i,
    input  logic [mem_bus_pkg::BE_W-1:0]    core_be_i,
    input  logic [mem_bus_pkg::DATA_W-1:0]  core_wdata_i,
    output logic                            core_gnt_o,

    // Stall settings
    input  perturb_pkg::stall_mode_e        stall_mode_i,
    input  logic [perturb_pkg::STALL_W-1:0] gnt_stall_i,
    input  logic [perturb_pkg::STALL_W-1:0] max_stall_i,
    input  logic [perturb_pkg::STALL_W-1:0] rand_i,

    // Room in the response queue
    input  logic                            can_accept_i,

    // Toward the scratch memory
    mem_req_if.requester                    mem
);
    import perturb_pkg::*;

    typedef enum logic {
        WAIT_REQ,
        COUNT
    } state_e;

    state_e             state_q;
    logic [STALL_W-1:0] cnt_q;
    logic [STALL_W-1:0] g_pick;
    logic               at_zero;

    // Fresh draw, only taken when a new request shows up in WAIT_REQ
    assign g_pick = pick_stall(stall_mode_i, gnt_stall_i, max_stall_i, rand_i);

    // Zero stall grants in the first cycle, otherwise wait for the counter
    assign at_zero = (state_q == WAIT_REQ) ? (g_pick == '0) : (cnt_q == '0);

    ////////////////////////////////
    // Request forwarding
    ////////////////////////////////

    // Fields pass straight through, req is what gets held back
    assign mem.addr  = core_addr_i;
    assign mem.we    = core_we_i;
    assign mem.be    = core_be_i;
    assign mem.wdata = core_wdata_i;

    // Queue must have room for the response before the access may go
    assign mem.req    = core_req_i && at_zero && can_accept_i;
    // Memory grants combinationally
    assign core_gnt_o = mem.gnt;

    ////////////////////////////////
    // Stall FSM
    ////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= WAIT_REQ;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                WAIT_REQ: begin
                    // Not granted in the first cycle, so start counting
                    if (core_req_i && !mem.gnt) begin
                        state_q <= COUNT;
                        // Cycle 0 already spent, grant lands in cycle G
                        cnt_q   <= (g_pick == '0) ? '0 : g_pick - 1'b1;
                    end
                end
                COUNT: begin
                    if (mem.gnt) begin
                        state_q <= WAIT_REQ;
                    end else if (cnt_q != '0) begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                    // At zero, sit here until can_accept_i lets it through
                end
                default: state_q <= WAIT_REQ;
            endcase
        end
    end

    // Memory side never grants an access the core is not asking for
    a_no_orphan_gnt: assert property (@(posedge clk_i) disable iff (reset_i)
        mem.gnt |-> core_req_i);

    // Core keeps its request and fields steady until granted
    a_core_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        (core_req_i && !core_gnt_o) |=>
            (core_req_i && $stable(core_addr_i) && $stable(core_we_i)
             && $stable(core_be_i) && $stable(core_wdata_i)));

endmodule

// ==== verilog/resp_stall_queue.sv ====
// Response stall stage that queues memory responses and hands each to the core after its own delay
`timescale 1ns/1ps

module resp_stall_queue (
    input  logic                            clk_i,
    input  logic                            reset_i,

    // From the scratch memory
    input  logic                            mem_rvalid_i,
    input  logic [mem_bus_pkg::DATA_W-1:0]  mem_rdata_i,
    input  logic                            mem_gnt_i,

    // Stall settings
    input  perturb_pkg::stall_mode_e        stall_mode_i,
    input  logic [perturb_pkg::STALL_W-1:0] valid_stall_i,
    input  logic [perturb_pkg::STALL_W-1:0] max_stall_i,
    input  logic [perturb_pkg::STALL_W-1:0] rand_i,

    // To the grant stage
    output logic                            can_accept_o,

    // Core data port, response side
    output logic                            core_rvalid_o,
    output logic [mem_bus_pkg::DATA_W-1:0]  core_rdata_o
);
    import perturb_pkg::*;
    import mem_bus_pkg::*;

    // Circular buffer of response data
    logic [DATA_W-1:0]     resp_buf_q [RESP_DEPTH];
    logic [RESP_PTR_W-1:0] wr_ptr_q;
    logic [RESP_PTR_W-1:0] rd_ptr_q;
    logic [RESP_CNT_W-1:0] count_q;
    // Granted accesses whose memory response has not arrived yet
    logic [RESP_CNT_W-1:0] inflight_q;

    // Head stall counter, armed once the head has its count
    logic                  armed_q;
    logic [STALL_W-1:0]    hold_q;

    logic                  head_valid;
    logic [STALL_W-1:0]    v_pick;
    logic                  pop;

    ////////////////////////////////
    // Head selection
    ////////////////////////////////

    // Empty queue with a response arriving, head is the incoming one
    assign head_valid = (count_q != '0) || mem_rvalid_i;

    assign v_pick = pick_stall(stall_mode_i, valid_stall_i, max_stall_i, rand_i);

    always_comb begin
        if (armed_q) begin
            pop = (hold_q == '0);
        end else begin
            // New head, zero stall releases it right away
            pop = head_valid && (v_pick == '0);
        end
    end

    assign core_rvalid_o = pop;
    // Bypass path when nothing is stored ahead of the incoming response
    assign core_rdata_o  = (count_q == '0) ? mem_rdata_i : resp_buf_q[rd_ptr_q];

    // Reserve a slot for every granted access before it is granted
    assign can_accept_o = ({1'b0, inflight_q} + {1'b0, count_q}) < RESP_DEPTH;

    ////////////////////////////////
    // Storage and counters
    ////////////////////////////////

    // Every response is written, a bypassed one is popped in the same cycle
    always_ff @(posedge clk_i) begin
        if (mem_rvalid_i) begin
            resp_buf_q[wr_ptr_q] <= mem_rdata_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            inflight_q <= '0;
            armed_q    <= 1'b0;
            hold_q     <= '0;
        end else begin
            if (mem_rvalid_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q    <= count_q + RESP_CNT_W'(mem_rvalid_i) - RESP_CNT_W'(pop);
            // Up on grant, down when the response lands in the queue
            inflight_q <= inflight_q + RESP_CNT_W'(mem_gnt_i) - RESP_CNT_W'(mem_rvalid_i);

            if (armed_q) begin
                // Next head draws its own count in the cycle after release
                if (pop) begin
                    armed_q <= 1'b0;
                end else begin
                    hold_q <= hold_q - 1'b1;
                end
            end else if (head_valid && (v_pick != '0)) begin
                armed_q <= 1'b1;
                // Arrival cycle counts as the first stall cycle
                hold_q  <= v_pick - 1'b1;
            end
        end
    end

    // Grant-side reservation keeps the buffer from overflowing
    a_no_push_full: assert property (@(posedge clk_i) disable iff (reset_i)
        mem_rvalid_i |-> (count_q < RESP_DEPTH));

    // With a nonzero fixed stall, strobes never sit in adjacent cycles
    a_strobe_gap: assert property (@(posedge clk_i) disable iff (reset_i)
        (core_rvalid_o && stall_mode_i == STALL_FIXED && valid_stall_i != '0) |=>
            !(core_rvalid_o && stall_mode_i == STALL_FIXED && valid_stall_i != '0));

endmodule

// ==== verilog/scratch_mem.sv ====
// Scratch word memory with byte enables that grants at once and answers one cycle later
`timescale 1ns/1ps

module scratch_mem (
    input  logic                           clk_i,
    input  logic                           reset_i,

    // Requests from the grant stage
    mem_req_if.responder                   bus,

    // Response strobe and data, one cycle after grant
    output logic                           rvalid_o,
    output logic [mem_bus_pkg::DATA_W-1:0] rdata_o
);
    import mem_bus_pkg::*;

    logic [DATA_W-1:0]    mem_q [MEM_WORDS];
    logic [MEM_IDX_W-1:0] idx;
    logic                 rvalid_q;
    logic [DATA_W-1:0]    rdata_q;

    // No wait states
    assign bus.gnt = bus.req;

    // Word index skips the byte offset
    assign idx = bus.addr[MEM_IDX_W+1:2];

    ////////////////////////////////
    // Array and read data
    ////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (bus.req) begin
            if (bus.we) begin
                for (int b = 0; b < BE_W; b++) begin
                    if (bus.be[b]) begin
                        mem_q[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                    end
                end
                // Writes answer with zero data
                rdata_q <= '0;
            end else begin
                rdata_q <= mem_q[idx];
            end
        end
    end

    // One strobe per granted access
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= bus.req;
        end
    end

    assign rvalid_o = rvalid_q;
    assign rdata_o  = rdata_q;

endmodule

// ==== verilog/perturb_top.sv ====
// Top level of the data-port perturbation unit, wiring the stall stages, LFSR and scratch memory
`timescale 1ns/1ps

module perturb_top (
    input  logic                            clk_i,
    input  logic                            reset_i,

    // Core data port
    input  logic                            core_req_i,
    input  logic [mem_bus_pkg::ADDR_W-1:0]  core_addr_i,
    input  logic                            core_we_i,
    input  logic [mem_bus_pkg::BE_W-1:0]    core_be_i,
    input  logic [mem_bus_pkg::DATA_W-1:0]  core_wdata_i,
    output logic                            core_gnt_o,
    output logic                            core_rvalid_o,
    output logic [mem_bus_pkg::DATA_W-1:0]  core_rdata_o,

    // Stall settings, held steady by the system
    input  logic [1:0]                      stall_mode_i,
    input  logic [perturb_pkg::STALL_W-1:0] gnt_stall_i,
    input  logic [perturb_pkg::STALL_W-1:0] valid_stall_i,
    input  logic [perturb_pkg::STALL_W-1:0] max_stall_i
);
    import perturb_pkg::*;
    import mem_bus_pkg::*;

    stall_mode_e       mode;
    logic [LFSR_W-1:0] rand_val;
    logic              can_accept;
    logic              mem_rvalid;
    logic [DATA_W-1:0] mem_rdata;

    // Grant stage to memory
    mem_req_if bus ();

    assign mode = stall_mode_e'(stall_mode_i);

    ////////////////////////////////
    // Random source
    ////////////////////////////////

    stall_lfsr i_lfsr (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .rand_o  (rand_val)
    );

    ////////////////////////////////
    // Request path
    ////////////////////////////////

    grant_stall_gen i_grant (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .core_req_i   (core_req_i),
        .core_addr_i  (core_addr_i),
        .core_we_i    (core_we_i),
        .core_be_i    (core_be_i),
        .core_wdata_i (core_wdata_i),
        .core_gnt_o   (core_gnt_o),
        .stall_mode_i (mode),
        .gnt_stall_i  (gnt_stall_i),
        .max_stall_i  (max_stall_i),
        // Low byte of the LFSR
        .rand_i       (rand_val[STALL_W-1:0]),
        .can_accept_i (can_accept),
        .mem          (bus.requester)
    );

    scratch_mem i_mem (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .bus      (bus.responder),
        .rvalid_o (mem_rvalid),
        .rdata_o  (mem_rdata)
    );

    ////////////////////////////////
    // Response path
    ////////////////////////////////

    resp_stall_queue i_resp (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .mem_rvalid_i  (mem_rvalid),
        .mem_rdata_i   (mem_rdata),
        .mem_gnt_i     (bus.gnt),
        .stall_mode_i  (mode),
        .valid_stall_i (valid_stall_i),
        .max_stall_i   (max_stall_i),
        // High byte, independent of the grant draw
        .rand_i        (rand_val[LFSR_W-1 -: STALL_W]),
        .can_accept_o  (can_accept),
        .core_rvalid_o (core_rvalid_o),
        .core_rdata_o  (core_rdata_o)
    );

endmodule

// ==== verification/perturb_checker.sv ====
// Testbench checker that watches the DUT ports, models the scratch memory and checks data and latency
`timescale 1ns/1ps

module perturb_checker (
    input  logic                            clk_i,
    input  logic                            reset_i,
    input  int                              test_id_i,

    // Stall settings as driven on the DUT
    input  logic [perturb_pkg::STALL_W-1:0] gnt_stall_i,
    input  logic [perturb_pkg::STALL_W-1:0] valid_stall_i,
    input  logic [perturb_pkg::STALL_W-1:0] max_stall_i,

    // Core data port of the DUT
    input  logic                            core_req_i,
    input  logic [mem_bus_pkg::ADDR_W-1:0]  core_addr_i,
    input  logic                            core_we_i,
    input  logic [mem_bus_pkg::BE_W-1:0]    core_be_i,
    input  logic [mem_bus_pkg::DATA_W-1:0]  core_wdata_i,
    input  logic                            core_gnt_i,
    input  logic                            core_rvalid_i,
    input  logic [mem_bus_pkg::DATA_W-1:0]  core_rdata_i,

    // Totals for the closing report
    output int                              err_cnt_o,
    output int                              check_cnt_o,
    output int                              resp_cnt_o
);
    import perturb_pkg::*;
    import mem_bus_pkg::*;

    // Upper bound where only a lower latency limit applies
    localparam int NO_LIMIT = 100000;

    // Model of the scratch memory
    logic [DATA_W-1:0]    ref_mem [MEM_WORDS];
    // Expected responses and their grant cycles, in grant order
    logic [DATA_W-1:0]    exp_q [$];
    int                   gnt_cyc_q [$];
    // Set when nothing was outstanding at grant, so no response can queue ahead
    logic                 alone_q [$];

    int                   cycle;
    int                   req_cycle;
    logic                 waiting;
    logic                 strobe_prev;
    int                   outstanding;
    int                   last_id;
    int                   test_gnts;
    int                   test_resps;
    int                   test_err_base;
    logic [MEM_IDX_W-1:0] idx;
    logic [DATA_W-1:0]    exp_val;
    int                   gnt_cyc;
    logic                 alone;

    function automatic string test_name(input int id);
        case (id)
            1: return "off_mode_mixed";
            2: return "fixed_single";
            3: return "random_order";
            4: return "random_byte_merge";
            5: return "fixed_pileup";
            default: return "idle";
        endcase
    endfunction

    ////////////////////////////////
    // Reference model
    ////////////////////////////////

    // Byte lanes with their enable set take the write data
    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old,
                                                      input logic [DATA_W-1:0] wdata,
                                                      input logic [BE_W-1:0]   be);
        logic [DATA_W-1:0] res;
        res = old;
        for (int b = 0; b < BE_W; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    // Reads return the stored word, writes answer with zero
    function automatic logic [DATA_W-1:0] expect_resp(input logic we,
                                                      input logic [DATA_W-1:0] stored);
        return we ? '0 : stored;
    endfunction

    ////////////////////////////////
    // Check helpers
    ////////////////////////////////

    task automatic check_data(input string what, input logic [DATA_W-1:0] expected,
                              input logic [DATA_W-1:0] actual);
        check_cnt_o++;
        if (expected !== actual) begin
            err_cnt_o++;
            $display("Error: test %s, %s expected 0x%08h actual 0x%08h",
                     test_name(last_id), what, expected, actual);
        end
    endtask

    task automatic check_range(input string what, input int lo, input int hi, input int actual);
        check_cnt_o++;
        if (actual < lo || actual > hi) begin
            err_cnt_o++;
            if (lo == hi) begin
                $display("Error: test %s, %s expected %0d actual %0d",
                         test_name(last_id), what, lo, actual);
            end else begin
                $display("Error: test %s, %s expected %0d to %0d actual %0d",
                         test_name(last_id), what, lo, hi, actual);
            end
        end
    endtask

    // Request to grant, counted from the first cycle of the request
    task automatic check_grant_latency(input int lat);
        case (last_id)
            1: check_range("grant latency", 0, 0, lat);
            2: check_range("grant latency", int'(gnt_stall_i), int'(gnt_stall_i), lat);
            3, 4: check_range("grant latency", 0, int'(max_stall_i), lat);
            default: ;
        endcase
    endtask

    // Grant to response strobe, one memory cycle plus the response stalls
    // A response queued behind another only has the lower limit
    task automatic check_resp_latency(input int lat, input logic solo);
        case (last_id)
            1: check_range("response latency", 1, 1, lat);
            2: check_range("response latency", 1 + int'(valid_stall_i),
                           1 + int'(valid_stall_i), lat);
            3, 4: check_range("response latency", 1,
                              solo ? 1 + int'(max_stall_i) : NO_LIMIT, lat);
            5: check_range("response latency", 1 + int'(valid_stall_i), NO_LIMIT, lat);
            default: ;
        endcase
    endtask

    task automatic finish_test();
        check_range("response count", test_gnts, test_gnts, test_resps);
        $display("Test %0d %s: %0d accesses, %0d errors", last_id, test_name(last_id),
                 test_gnts, err_cnt_o - test_err_base);
    endtask

    ////////////////////////////////
    // Monitor, sampled mid-cycle
    ////////////////////////////////

    always @(negedge clk_i) begin
        if (reset_i) begin
            cycle       = 0;
            waiting     = 1'b0;
            strobe_prev = 1'b0;
            outstanding = 0;
            last_id     = 0;
            err_cnt_o   = 0;
            check_cnt_o = 0;
            resp_cnt_o  = 0;
        end else begin
            cycle = cycle + 1;
            // New test id closes the previous test
            if (test_id_i != last_id) begin
                if (last_id != 0) begin
                    finish_test();
                end
                last_id       = test_id_i;
                test_gnts     = 0;
                test_resps    = 0;
                test_err_base = err_cnt_o;
            end
            if (core_req_i && !waiting) begin
                waiting   = 1'b1;
                req_cycle = cycle;
            end
            if (core_gnt_i) begin
                idx = core_addr_i[MEM_IDX_W+1:2];
                check_grant_latency(cycle - req_cycle);
                exp_q.push_back(expect_resp(core_we_i, ref_mem[idx]));
                gnt_cyc_q.push_back(cycle);
                alone_q.push_back(outstanding == 0);
                if (core_we_i) begin
                    ref_mem[idx] = merge_bytes(ref_mem[idx], core_wdata_i, core_be_i);
                end
                waiting = 1'b0;
                test_gnts++;
                outstanding++;
                if (last_id == 5) begin
                    check_range("unanswered grants", 0, RESP_DEPTH, outstanding);
                end
            end
            if (core_rvalid_i) begin
                if (last_id == 5 && strobe_prev) begin
                    err_cnt_o++;
                    $display("Test %s: response strobe stayed high for two cycles in a row",
                             test_name(last_id));
                end
                if (exp_q.size() == 0) begin
                    err_cnt_o++;
                    $display("Test %s: response strobe with no access outstanding",
                             test_name(last_id));
                end else begin
                    exp_val = exp_q.pop_front();
                    gnt_cyc = gnt_cyc_q.pop_front();
                    alone   = alone_q.pop_front();
                    check_data("response data", exp_val, core_rdata_i);
                    check_resp_latency(cycle - gnt_cyc, alone);
                    outstanding--;
                end
                test_resps++;
                resp_cnt_o++;
            end
            strobe_prev = core_rvalid_i;
        end
    end

endmodule

// ==== verification/perturb_tb.sv ====
// Testbench top for the perturbation unit, drives the core port through all stall modes and reports
`timescale 1ns/1ps

module perturb_tb;
    import perturb_pkg::*;
    import mem_bus_pkg::*;

    localparam int RAND_SEED     = 12;
    // Accesses per test, test 4 splits them into write and read pairs
    localparam int N_ACCESS      = 40;
    localparam int PRELOAD_WORDS = 64;
    // Worst access near 25 cycles: 7 grant stalls, 8 response cycles, drain turnaround
    localparam int TIMEOUT_CYCLES = (PRELOAD_WORDS + 5 * N_ACCESS) * 25 + 1400;

    logic                clk_i;
    logic                reset_i;
    logic                core_req_i;
    logic [ADDR_W-1:0]   core_addr_i;
    logic                core_we_i;
    logic [BE_W-1:0]     core_be_i;
    logic [DATA_W-1:0]   core_wdata_i;
    logic                core_gnt_o;
    logic                core_rvalid_o;
    logic [DATA_W-1:0]   core_rdata_o;
    logic [1:0]          stall_mode_i;
    logic [STALL_W-1:0]  gnt_stall_i;
    logic [STALL_W-1:0]  valid_stall_i;
    logic [STALL_W-1:0]  max_stall_i;

    int                  test_id;
    int                  issued;
    int                  err_cnt;
    int                  check_cnt;
    int                  resp_cnt;
    int                  cycle_cnt;
    logic [31:0]         rnd;
    logic [BE_W-1:0]     be_part;

    perturb_top i_dut (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .core_req_i    (core_req_i),
        .core_addr_i   (core_addr_i),
        .core_we_i     (core_we_i),
        .core_be_i     (core_be_i),
        .core_wdata_i  (core_wdata_i),
        .core_gnt_o    (core_gnt_o),
        .core_rvalid_o (core_rvalid_o),
        .core_rdata_o  (core_rdata_o),
        .stall_mode_i  (stall_mode_i),
        .gnt_stall_i   (gnt_stall_i),
        .valid_stall_i (valid_stall_i),
        .max_stall_i   (max_stall_i)
    );

    perturb_checker i_chk (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .test_id_i     (test_id),
        .gnt_stall_i   (gnt_stall_i),
        .valid_stall_i (valid_stall_i),
        .max_stall_i   (max_stall_i),
        .core_req_i    (core_req_i),
        .core_addr_i   (core_addr_i),
        .core_we_i     (core_we_i),
        .core_be_i     (core_be_i),
        .core_wdata_i  (core_wdata_i),
        .core_gnt_i    (core_gnt_o),
        .core_rvalid_i (core_rvalid_o),
        .core_rdata_i  (core_rdata_o),
        .err_cnt_o     (err_cnt),
        .check_cnt_o   (check_cnt),
        .resp_cnt_o    (resp_cnt)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    ////////////////////////////////
    // Driver tasks
    ////////////////////////////////

    // Preload word, every byte derived from the byte address
    function automatic logic [DATA_W-1:0] fill_word(input logic [7:0] addr);
        return {addr ^ 8'hC3, ~addr, addr + 8'h5A, addr};
    endfunction

    // Holds one access until grant, returns 2 ns after the transfer edge
    task automatic issue(input logic we, input logic [5:0] word, input logic [BE_W-1:0] be,
                         input logic [DATA_W-1:0] wdata);
        core_req_i   = 1'b1;
        core_we_i    = we;
        core_addr_i  = {24'h0, word, 2'b00};
        core_be_i    = be;
        core_wdata_i = wdata;
        @(negedge clk_i);
        while (!core_gnt_o) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #2;
        core_req_i = 1'b0;
        issued++;
    endtask

    // Waits until every issued access has had its response
    task automatic drain();
        while (resp_cnt != issued) begin
            @(posedge clk_i);
            #2;
        end
    endtask

    task automatic issue_random(input logic wait_resp);
        logic [31:0] r;
        r = $urandom;
        issue(r[0], r[6:1], r[10:7], $urandom);
        if (wait_resp) begin
            drain();
        end
    endtask

    // Settings change only while the DUT is idle
    task automatic configure(input int id, input stall_mode_e mode, input logic [7:0] g,
                             input logic [7:0] v, input logic [7:0] m);
        stall_mode_i  = mode;
        gnt_stall_i   = g;
        valid_stall_i = v;
        max_stall_i   = m;
        test_id       = id;
    endtask

    ////////////////////////////////
    // Test sequence
    ////////////////////////////////

    initial begin
        reset_i       = 1'b1;
        core_req_i    = 1'b0;
        core_addr_i   = '0;
        core_we_i     = 1'b0;
        core_be_i     = '0;
        core_wdata_i  = '0;
        stall_mode_i  = STALL_OFF;
        gnt_stall_i   = '0;
        valid_stall_i = '0;
        max_stall_i   = '0;
        test_id       = 0;
        issued        = 0;
        void'($urandom(RAND_SEED));
        repeat (5) @(posedge clk_i);
        #2;
        reset_i = 1'b0;
        @(posedge clk_i);
        #2;

        // No stalls, memory filled first so that every read has known data
        configure(1, STALL_OFF, 8'd0, 8'd0, 8'd0);
        for (int w = 0; w < PRELOAD_WORDS; w++) begin
            issue(1'b1, w[5:0], 4'hF, fill_word({w[5:0], 2'b00}));
        end
        repeat (N_ACCESS) issue_random(1'b0);
        drain();

        configure(2, STALL_FIXED, 8'd3, 8'd2, 8'd0);
        repeat (N_ACCESS) issue_random(1'b1);

        // Pairs back to back, so that a second response can wait behind the first
        configure(3, STALL_RANDOM, 8'd0, 8'd0, 8'd7);
        repeat (N_ACCESS / 2) begin
            issue_random(1'b0);
            issue_random(1'b1);
        end

        // Partial write, then read back the merged word
        configure(4, STALL_RANDOM, 8'd0, 8'd0, 8'd7);
        repeat (N_ACCESS / 2) begin
            rnd     = $urandom;
            be_part = (rnd[3:0] == 4'h0 || rnd[3:0] == 4'hF) ? 4'h6 : rnd[3:0];
            issue(1'b1, rnd[9:4], be_part, $urandom);
            drain();
            issue(1'b0, rnd[9:4], 4'hF, '0);
            drain();
        end

        // Long response stall with back-to-back requests fills the queue
        configure(5, STALL_FIXED, 8'd0, 8'd10, 8'd0);
        repeat (N_ACCESS) issue_random(1'b0);
        drain();

        test_id = 0;
        @(posedge clk_i);
        @(posedge clk_i);
        #2;
        $display("Summary: 5 tests, %0d accesses, %0d responses, %0d checks, %0d errors",
                 issued, resp_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Run limit
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("Timeout: run stopped after %0d cycles in test %0d with %0d of %0d responses",
                 cycle_cnt, test_id, resp_cnt, issued);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== sources.f ====
verilog/perturb_pkg.sv
verilog/mem_bus_pkg.sv
verilog/mem_req_if.sv
verilog/stall_lfsr.sv
verilog/grant_stall_gen.sv
verilog/resp_stall_queue.sv
verilog/scratch_mem.sv
verilog/perturb_top.sv
verification/perturb_checker.sv
verification/perturb_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the perturbation unit testbench with Verilator, runs it and looks for the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module perturb_tb -o perturb_sim

out=$(./obj_dir/perturb_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
    exit 0
fi
exit 1
